// ==== source/lsuPkg.sv ====
// Load/store unit shared types
// Widths, operation encodings and FSM states

package lsuPkg;

  // Fixed RV32 data path
  localparam int xlen = 32;
  localparam int adrBits = 32;
  localparam int maskBits = xlen / 8;

  // Kind of memory operation requested by the core
  typedef enum logic [1:0] {
    opLoad             = 2'b00,
    opStore            = 2'b01,
    opLoadReserved     = 2'b10,
    opStoreConditional = 2'b11
  } memOp;

  // Access size, encoded as the RISC-V funct3 field of loads and stores
  typedef enum logic [2:0] {
    sizeByte  = 3'b000,
    sizeHalf  = 3'b001,
    sizeWord  = 3'b010,
    sizeByteU = 3'b100,
    sizeHalfU = 3'b101
  } accessSize;

  // Core-side sequencing in lsuControl
  typedef enum logic [1:0] {
    ctrlIdle,
    ctrlBus,
    ctrlDone
  } ctrlState;

  // External port sequencing in lsuBus
  typedef enum logic [1:0] {
    busIdle,
    busWaitAck,
    busWaitDrop
  } busState;

  // Reverses the byte order of a word, used by both store and load paths
  function automatic logic [xlen-1:0] byteSwap(input logic [xlen-1:0] word);
    logic [xlen-1:0] swapped;
    for (int i = 0; i < maskBits; i++) begin
      swapped[8*i +: 8] = word[8*(maskBits-1-i) +: 8];
    end
    return swapped;
  endfunction

endpackage

// ==== source/lsuBusIf.sv ====
// Internal memory transaction bundle

`timescale 1ns/1ps

interface lsuBusIf;

  // Four-phase handshake pair
  logic req;
  logic ack;

  // Request payload, held by the controller while req is high
  logic [lsuPkg::adrBits-1:0] adr;
  logic write;
  logic [lsuPkg::xlen-1:0] wdata;
  logic [lsuPkg::maskBits-1:0] mask;

  // Read word returned with ack
  logic [lsuPkg::xlen-1:0] rdata;

  // Controller side issues the request
  modport ctrl (
    output req, adr, write, wdata, mask,
    input  ack, rdata
  );

  // Bus master side answers it
  modport bus (
    input  req, adr, write, wdata, mask,
    output ack, rdata
  );

endinterface

// ==== source/subwordWrite.sv ====
// Store lane placement and byte mask

`timescale 1ns/1ps

module subwordWrite (
  input  lsuPkg::accessSize size,
  input  logic [1:0] adrLow,
  input  logic bigEndian,
  input  logic [lsuPkg::xlen-1:0] writeData,
  output logic [lsuPkg::xlen-1:0] storeLanes,
  output logic [lsuPkg::maskBits-1:0] storeMask
);

  // Little-endian lanes and mask before the optional swap
  logic [lsuPkg::xlen-1:0] littleLanes;
  logic [lsuPkg::maskBits-1:0] littleMask;
  logic [lsuPkg::maskBits-1:0] swappedMask;

  ////////////////////////////////////////////////////////////
  // Lane replication and mask
  ////////////////////////////////////////////////////////////

  // The value is copied into every lane it could occupy, so the mask alone
  // decides which bytes memory takes
  always_comb begin
    case (size)
      lsuPkg::sizeByte, lsuPkg::sizeByteU: begin
        littleLanes = {4{writeData[7:0]}};
        littleMask = 4'b0001 << adrLow;
      end
      lsuPkg::sizeHalf, lsuPkg::sizeHalfU: begin
        littleLanes = {2{writeData[15:0]}};
        // A half only sits in the low or the high pair of lanes
        littleMask = adrLow[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        littleLanes = writeData;
        littleMask = 4'b1111;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Big-endian swap
  ////////////////////////////////////////////////////////////

  // Mask bits follow their bytes when the lanes are reversed
  always_comb begin
    for (int i = 0; i < lsuPkg::maskBits; i++) begin
      swappedMask[i] = littleMask[lsuPkg::maskBits-1-i];
    end
  end

  // Memory then holds the word in big-endian order
  assign storeLanes = bigEndian ? lsuPkg::byteSwap(littleLanes) : littleLanes;
  assign storeMask = bigEndian ? swappedMask : littleMask;

endmodule

// ==== source/subwordRead.sv ====
// Load extraction and extension

`timescale 1ns/1ps

module subwordRead (
  input  logic [lsuPkg::xlen-1:0] word,
  input  lsuPkg::accessSize size,
  input  logic [1:0] adrLow,
  input  logic bigEndian,
  output logic [lsuPkg::xlen-1:0] loadValue
);

  // Word in little-endian byte order, as the core sees it
  logic [lsuPkg::xlen-1:0] littleWord;
  logic [7:0] byteSel;
  logic [15:0] halfSel;

  // Undo the big-endian layout first so the lane choice below is the same
  // for both byte orders
  assign littleWord = bigEndian ? lsuPkg::byteSwap(word) : word;

  ////////////////////////////////////////////////////////////
  // Lane selection
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (adrLow)
      2'b00: byteSel = littleWord[7:0];
      2'b01: byteSel = littleWord[15:8];
      2'b10: byteSel = littleWord[23:16];
      default: byteSel = littleWord[31:24];
    endcase
  end

  // Halves are aligned, so only address bit 1 matters here
  assign halfSel = adrLow[1] ? littleWord[31:16] : littleWord[15:0];

  ////////////////////////////////////////////////////////////
  // Sign or zero extension
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (size)
      lsuPkg::sizeByte: begin
        loadValue = {{(lsuPkg::xlen-8){byteSel[7]}}, byteSel};
      end
      lsuPkg::sizeByteU: begin
        loadValue = {{(lsuPkg::xlen-8){1'b0}}, byteSel};
      end
      lsuPkg::sizeHalf: begin
        loadValue = {{(lsuPkg::xlen-16){halfSel[15]}}, halfSel};
      end
      lsuPkg::sizeHalfU: begin
        loadValue = {{(lsuPkg::xlen-16){1'b0}}, halfSel};
      end
      default: begin
        // Word loads and LR pass the whole word through
        loadValue = littleWord;
      end
    endcase
  end

endmodule

// ==== source/lsuBus.sv ====
// External memory port master

`timescale 1ns/1ps

module lsuBus (
  input  logic clk,
  input  logic reset,
  lsuBusIf.bus txn,
  output logic busReq,
  input  logic busAck,
  output logic [lsuPkg::adrBits-1:0] busAdr,
  output logic busWrite,
  output logic [lsuPkg::xlen-1:0] busWdata,
  output logic [lsuPkg::maskBits-1:0] busMask,
  input  logic [lsuPkg::xlen-1:0] busRdata
);

  lsuPkg::busState state;

  // Start only on a fresh request, with the external port fully idle
  logic startTxn;
  // External slave answered the current request
  logic slaveAck;
  // Both sides have returned to idle
  logic bothDropped;

  assign startTxn = (state == lsuPkg::busIdle) & txn.req & ~txn.ack & ~busAck;
  assign slaveAck = (state == lsuPkg::busWaitAck) & busAck;
  assign bothDropped = (state == lsuPkg::busWaitDrop) & ~busAck & ~txn.req;

  ////////////////////////////////////////////////////////////
  // Handshake FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= lsuPkg::busIdle;
      busReq <= 1'b0;
      txn.ack <= 1'b0;
    end else begin
      case (state)
        lsuPkg::busIdle: begin
          if (startTxn) begin
            busReq <= 1'b1;
            state <= lsuPkg::busWaitAck;
          end
        end
        lsuPkg::busWaitAck: begin
          // Our request drops in the same cycle that the controller sees ack
          if (slaveAck) begin
            busReq <= 1'b0;
            txn.ack <= 1'b1;
            state <= lsuPkg::busWaitDrop;
          end
        end
        lsuPkg::busWaitDrop: begin
          // The external slave and the controller may release in either order
          if (bothDropped) begin
            txn.ack <= 1'b0;
            state <= lsuPkg::busIdle;
          end
        end
        default: begin
          state <= lsuPkg::busIdle;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Payload registers
  ////////////////////////////////////////////////////////////

  // Loaded only when a transaction starts, so the port is steady while busReq is high
  always_ff @(posedge clk) begin
    if (startTxn) begin
      busAdr <= txn.adr;
      busWrite <= txn.write;
      busWdata <= txn.wdata;
      busMask <= txn.mask;
    end
    // Read word is taken with the slave's ack and held for the controller
    if (slaveAck) begin
      txn.rdata <= busRdata;
    end
  end

endmodule

// ==== source/lsuControl.sv ====
// Core handshake, fault check and LR/SC reservation

`timescale 1ns/1ps

module lsuControl (
  input  logic clk,
  input  logic reset,
  input  logic memReq,
  output logic memAck,
  input  lsuPkg::memOp memOp,
  input  lsuPkg::accessSize size,
  input  logic [lsuPkg::adrBits-1:0] adr,
  input  logic [lsuPkg::xlen-1:0] storeLanes,
  input  logic [lsuPkg::maskBits-1:0] storeMask,
  input  logic [lsuPkg::xlen-1:0] loadValue,
  output logic loadMisaligned,
  output logic storeMisaligned,
  output logic scFail,
  output logic [lsuPkg::xlen-1:0] readData,
  lsuBusIf.ctrl txn,
  output logic [lsuPkg::xlen-1:0] wordOut
);

  lsuPkg::ctrlState state;

  // Operation decode
  logic isRead, isWrite, isLr, isSc;
  logic halfAccess, wordAccess, misaligned;

  // Reservation on one word address
  logic resValid;
  logic [lsuPkg::adrBits-3:0] resAdr;
  logic resHit, scReject;

  // FSM events
  logic startOp, quickDone, busStart, ackSeen, busFinish;

  ////////////////////////////////////////////////////////////
  // Decode and alignment check
  ////////////////////////////////////////////////////////////

  assign isLr = memOp == lsuPkg::opLoadReserved;
  assign isSc = memOp == lsuPkg::opStoreConditional;
  assign isRead = (memOp == lsuPkg::opLoad) | isLr;
  assign isWrite = (memOp == lsuPkg::opStore) | isSc;

  // LR and SC are word operations whatever the size field says
  assign halfAccess = (size == lsuPkg::sizeHalf) | (size == lsuPkg::sizeHalfU);
  assign wordAccess = (size == lsuPkg::sizeWord) | isLr | isSc;
  assign misaligned = (wordAccess & (|adr[1:0])) | (halfAccess & adr[0]);

  // An SC goes to memory only with a live reservation on its own word
  assign resHit = resValid & (resAdr == adr[lsuPkg::adrBits-1:2]);
  assign scReject = isSc & ~resHit & ~misaligned;

  // Faults and rejected SCs finish without a bus transaction
  assign startOp = (state == lsuPkg::ctrlIdle) & memReq;
  assign quickDone = startOp & (misaligned | scReject);
  assign busStart = startOp & ~misaligned & ~scReject;

  // The bus master returns data first and both handshake lines go low after it
  assign ackSeen = (state == lsuPkg::ctrlBus) & txn.req & txn.ack;
  assign busFinish = (state == lsuPkg::ctrlBus) & ~txn.req & ~txn.ack;

  ////////////////////////////////////////////////////////////
  // Control FSM and reservation
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= lsuPkg::ctrlIdle;
      memAck <= 1'b0;
      txn.req <= 1'b0;
      resValid <= 1'b0;
    end else begin
      case (state)
        lsuPkg::ctrlIdle: begin
          if (quickDone) begin
            memAck <= 1'b1;
            state <= lsuPkg::ctrlDone;
          end else if (busStart) begin
            txn.req <= 1'b1;
            state <= lsuPkg::ctrlBus;
          end
        end
        lsuPkg::ctrlBus: begin
          // memAck waits until the internal handshake has fully closed
          if (ackSeen) begin
            txn.req <= 1'b0;
          end else if (busFinish) begin
            memAck <= 1'b1;
            state <= lsuPkg::ctrlDone;
          end
        end
        lsuPkg::ctrlDone: begin
          if (!memReq) begin
            memAck <= 1'b0;
            state <= lsuPkg::ctrlIdle;
          end
        end
        default: begin
          state <= lsuPkg::ctrlIdle;
        end
      endcase
      // Every SC ends the reservation, as does a store that hits its word
      if (startOp & (isSc | (isWrite & resHit))) begin
        resValid <= 1'b0;
      end else if (startOp & isLr & ~misaligned) begin
        resValid <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Request and result registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    // A faulting LR leaves any live reservation where it was
    if (startOp & isLr & ~misaligned) begin
      resAdr <= adr[lsuPkg::adrBits-1:2];
    end
    // The word-aligned request is held for the whole internal transaction
    if (busStart) begin
      txn.adr <= {adr[lsuPkg::adrBits-1:2], 2'b00};
      txn.write <= isWrite;
      txn.wdata <= storeLanes;
      txn.mask <= storeMask;
    end
    if (ackSeen) begin
      wordOut <= txn.rdata;
    end
    // A rejected SC reports 1 in readData and a fault reports 0
    if (quickDone) begin
      readData <= {{(lsuPkg::xlen-1){1'b0}}, scReject};
      loadMisaligned <= misaligned & isRead;
      storeMisaligned <= misaligned & isWrite;
      scFail <= scReject;
    end
    // loadValue is built from the wordOut captured at least a cycle earlier
    if (busFinish) begin
      readData <= isRead ? loadValue : '0;
      loadMisaligned <= 1'b0;
      storeMisaligned <= 1'b0;
      scFail <= 1'b0;
    end
  end

endmodule

// ==== source/lsu.sv ====
// Load/store unit top level

`timescale 1ns/1ps

module lsu (
  input  logic clk,
  input  logic reset,
  // Core request and result
  input  logic memReq,
  output logic memAck,
  input  lsuPkg::memOp memOp,
  input  lsuPkg::accessSize size,
  input  logic [lsuPkg::adrBits-1:0] adr,
  input  logic [lsuPkg::xlen-1:0] writeData,
  input  logic bigEndian,
  output logic [lsuPkg::xlen-1:0] readData,
  output logic loadMisaligned,
  output logic storeMisaligned,
  output logic scFail,
  // External memory port
  output logic busReq,
  input  logic busAck,
  output logic [lsuPkg::adrBits-1:0] busAdr,
  output logic busWrite,
  output logic [lsuPkg::xlen-1:0] busWdata,
  output logic [lsuPkg::maskBits-1:0] busMask,
  input  logic [lsuPkg::xlen-1:0] busRdata
);

  // Data path between the subword blocks and the controller
  logic [lsuPkg::xlen-1:0] storeLanes;
  logic [lsuPkg::maskBits-1:0] storeMask;
  logic [lsuPkg::xlen-1:0] loadValue;
  logic [lsuPkg::xlen-1:0] wordOut;

  lsuBusIf txn();

  ////////////////////////////////////////////////////////////
  // Subword data path
  ////////////////////////////////////////////////////////////

  subwordWrite storeAlign (
    .size(size),
    .adrLow(adr[1:0]),
    .bigEndian(bigEndian),
    .writeData(writeData),
    .storeLanes(storeLanes),
    .storeMask(storeMask)
  );

  // Works on the captured bus word while the core holds size and address
  subwordRead loadAlign (
    .word(wordOut),
    .size(size),
    .adrLow(adr[1:0]),
    .bigEndian(bigEndian),
    .loadValue(loadValue)
  );

  ////////////////////////////////////////////////////////////
  // Control and bus
  ////////////////////////////////////////////////////////////

  lsuControl control (
    .clk(clk),
    .reset(reset),
    .memReq(memReq),
    .memAck(memAck),
    .memOp(memOp),
    .size(size),
    .adr(adr),
    .storeLanes(storeLanes),
    .storeMask(storeMask),
    .loadValue(loadValue),
    .loadMisaligned(loadMisaligned),
    .storeMisaligned(storeMisaligned),
    .scFail(scFail),
    .readData(readData),
    .txn(txn.ctrl),
    .wordOut(wordOut)
  );

  lsuBus busMaster (
    .clk(clk),
    .reset(reset),
    .txn(txn.bus),
    .busReq(busReq),
    .busAck(busAck),
    .busAdr(busAdr),
    .busWrite(busWrite),
    .busWdata(busWdata),
    .busMask(busMask),
    .busRdata(busRdata)
  );

endmodule

// ==== tb/busMemory.sv ====
// Behavioural memory on the external port

`timescale 1ns/1ps

module busMemory (
  input  logic clk,
  input  logic reset,
  input  logic busReq,
  output logic busAck,
  input  logic [lsuPkg::adrBits-1:0] busAdr,
  input  logic busWrite,
  input  logic [lsuPkg::xlen-1:0] busWdata,
  input  logic [lsuPkg::maskBits-1:0] busMask,
  output logic [lsuPkg::xlen-1:0] busRdata
);

  // 256 words, indexed by address bits 9:2
  logic [lsuPkg::xlen-1:0] words [0:255];
  logic [31:0] rngState;
  int delayLeft;
  bit counting;

  // One xorshift32 step
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  initial begin
    for (int i = 0; i < 256; i++) begin
      words[i] = '0;
    end
    rngState = 32'hddbfc090;
    busAck = 1'b0;
    busRdata = '0;
    counting = 1'b0;
    delayLeft = 0;
  end

  // Slave side of the four-phase port, updated 1 ns after each rising edge
  always begin
    @(posedge clk);
    #1;
    if (reset) begin
      busAck = 1'b0;
      counting = 1'b0;
    end else if (busAck) begin
      // Release only once the master has dropped its request
      if (!busReq) begin
        busAck = 1'b0;
      end
    end else if (busReq) begin
      // A fresh request draws a delay of zero to four cycles
      if (!counting) begin
        rngState = xorshift(rngState);
        delayLeft = int'(rngState % 5);
        counting = 1'b1;
      end
      if (delayLeft == 0) begin
        if (busWrite) begin
          for (int i = 0; i < lsuPkg::maskBits; i++) begin
            if (busMask[i]) begin
              words[busAdr[9:2]][8*i +: 8] = busWdata[8*i +: 8];
            end
          end
        end
        busRdata = words[busAdr[9:2]];
        busAck = 1'b1;
        counting = 1'b0;
      end else begin
        delayLeft--;
      end
    end
  end

endmodule

// ==== tb/lsuBus_assert.sv ====
// Handshake checks on the bus master

`timescale 1ns/1ps

module lsuBusAssert (
  input logic clk,
  input logic reset,
  input logic busReq,
  input logic busAck,
  input logic [lsuPkg::adrBits-1:0] busAdr,
  input logic busWrite,
  input logic [lsuPkg::xlen-1:0] busWdata,
  input logic [lsuPkg::maskBits-1:0] busMask,
  input logic txnReq,
  input logic txnAck
);

  // Failed assertion count
  int failures = 0;

  // A new external request waits until the previous ack has gone low
  reqWaitsForAckLow: assert property (@(posedge clk) disable iff (reset)
    (!busReq && busAck) |=> !busReq)
    else begin
      failures++;
      $error("busReq rose while busAck was still high");
    end

  // Payload is frozen for as long as the request stays up
  payloadStable: assert property (@(posedge clk) disable iff (reset)
    (busReq && $past(busReq)) |-> $stable({busAdr, busWrite, busWdata, busMask}))
    else begin
      failures++;
      $error("External port payload changed while busReq was high");
    end

  // The internal ack may only drop after the controller let go of req
  ackFallsAfterReq: assert property (@(posedge clk) disable iff (reset)
    $fell(txnAck) |-> !$past(txnReq))
    else begin
      failures++;
      $error("Internal ack fell while req was still high");
    end

endmodule

bind lsuBus lsuBusAssert handshakeChecks (
  .clk(clk),
  .reset(reset),
  .busReq(busReq),
  .busAck(busAck),
  .busAdr(busAdr),
  .busWrite(busWrite),
  .busWdata(busWdata),
  .busMask(busMask),
  .txnReq(txn.req),
  .txnAck(txn.ack)
);

// ==== tb/lsuTb.sv ====
// Load/store unit testbench

`timescale 1ns/1ps

module lsuTb;

  logic clk = 1'b0;
  logic reset;
  logic memReq, memAck, bigEndian;
  lsuPkg::memOp memOp;
  lsuPkg::accessSize size;
  logic [lsuPkg::adrBits-1:0] adr;
  logic [lsuPkg::xlen-1:0] writeData, readData;
  logic loadMisaligned, storeMisaligned, scFail;
  logic busReq, busAck, busWrite;
  logic [lsuPkg::adrBits-1:0] busAdr;
  logic [lsuPkg::xlen-1:0] busWdata, busRdata;
  logic [lsuPkg::maskBits-1:0] busMask;

  // One line of the test file
  string line, testName;
  int fd, scanCount;
  logic [31:0] opField, sizeField, adrField, dataField, beField;
  logic [31:0] expRead, expLoadMis, expStoreMis, expScFail;
  int errorCount = 0;
  int timeoutCount = 0;
  int assertFailures = 0;
  int testCount = 0;
  bit timedOut = 1'b0;

  always #4 clk = ~clk;

  lsu dut_i (.*);

  busMemory memory (.*);

  ////////////////////////////////////////////////////////////
  // Checks and handshake helpers
  ////////////////////////////////////////////////////////////

  task automatic compareField(input string field, input logic [31:0] expected,
                              input logic [31:0] actual);
    assert (actual === expected) else begin
      errorCount++;
      $display("[ERROR] %s %s: expected %h, actual %h", testName, field, expected, actual);
    end
  endtask

  // Polls memAck 1 ns after each edge until it reaches the wanted level
  task automatic waitForAck(input logic level);
    int cycles;
    cycles = 0;
    @(posedge clk);
    #1;
    while (memAck !== level && cycles < 200) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (memAck !== level) begin
      timedOut = 1'b1;
      timeoutCount++;
      $display("Timeout in %s: memAck never went to %0b", testName, level);
    end
  endtask

  // Full core-side four-phase cycle for the operation just read
  task automatic runOperation();
    @(posedge clk);
    #1;
    memOp = lsuPkg::memOp'(opField[1:0]);
    size = lsuPkg::accessSize'(sizeField[2:0]);
    adr = adrField;
    writeData = dataField;
    bigEndian = beField[0];
    memReq = 1'b1;
    waitForAck(1'b1);
    if (!timedOut) begin
      // Results are held steady while memAck is high
      compareField("readData", expRead, readData);
      compareField("loadMisaligned", expLoadMis, {31'b0, loadMisaligned});
      compareField("storeMisaligned", expStoreMis, {31'b0, storeMisaligned});
      compareField("scFail", expScFail, {31'b0, scFail});
      memReq = 1'b0;
      waitForAck(1'b0);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    reset = 1'b1;
    memReq = 1'b0;
    memOp = lsuPkg::opLoad;
    size = lsuPkg::sizeWord;
    adr = '0;
    writeData = '0;
    bigEndian = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    fd = $fopen("tb/lsuTests.txt", "r");
    if (fd == 0) begin
      errorCount++;
      $display("Could not open the test file tb/lsuTests.txt");
    end else begin
      while (!$feof(fd) && !timedOut) begin
        if ($fgets(line, fd) == 0) continue;
        // Blank lines and lines starting with # carry no operation
        if (line.len() < 2 || line[0] == "#") continue;
        scanCount = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", testName, opField,
                            sizeField, adrField, dataField, beField, expRead, expLoadMis,
                            expStoreMis, expScFail);
        if (scanCount != 10) begin
          errorCount++;
          $display("Malformed line in test file: %s", line);
          continue;
        end
        testCount++;
        runOperation();
      end
      $fclose(fd);
    end
    // Handshake assertion failures in the bus master also fail the run
    assertFailures = dut_i.busMaster.handshakeChecks.failures;
    $display("Ran %0d tests with %0d errors, %0d timeouts and %0d assertion failures",
             testCount, errorCount, timeoutCount, assertFailures);
    if (errorCount == 0 && timeoutCount == 0 && assertFailures == 0 && testCount > 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
source/lsuPkg.sv
source/lsuBusIf.sv
source/subwordWrite.sv
source/subwordRead.sv
source/lsuBus.sv
source/lsuControl.sv
source/lsu.sv
tb/busMemory.sv
tb/lsuBus_assert.sv
tb/lsuTb.sv

// ==== tb/lsuTests.txt ====
# name op size adr wdata bigEndian | readData loadMisaligned storeMisaligned scFail
# all hex; op 0 load 1 store 2 LR 3 SC; size is funct3 (0 b, 1 h, 2 w, 4 bu, 5 hu)
swWord        1 2 00000100 11223344 0 00000000 0 0 0
lwWord        0 2 00000100 00000000 0 11223344 0 0 0
sbByte        1 0 00000101 000000aa 0 00000000 0 0 0
shHalf        1 1 00000102 0000beef 0 00000000 0 0 0
lwMerged      0 2 00000100 00000000 0 beefaa44 0 0 0
lbSigned      0 0 00000101 00000000 0 ffffffaa 0 0 0
lbuUnsigned   0 4 00000101 00000000 0 000000aa 0 0 0
lhSigned      0 1 00000102 00000000 0 ffffbeef 0 0 0
lhuUnsigned   0 5 00000102 00000000 0 0000beef 0 0 0
lbPositive    0 0 00000100 00000000 0 00000044 0 0 0
swBig         1 2 00000104 11223344 1 00000000 0 0 0
lbLittleOfBig 0 0 00000104 00000000 0 00000011 0 0 0
lwBig         0 2 00000104 00000000 1 11223344 0 0 0
lwLittleOfBig 0 2 00000104 00000000 0 44332211 0 0 0
shBig         1 1 00000106 0000a1b2 1 00000000 0 0 0
lhBig         0 1 00000106 00000000 1 ffffa1b2 0 0 0
lbuLittle     0 4 00000104 00000000 0 000000a1 0 0 0
shMisaligned  1 1 00000101 00005555 0 00000000 0 1 0
swMisaligned  1 2 00000102 66666666 0 00000000 0 1 0
lwMisaligned  0 2 00000103 00000000 0 00000000 1 0 0
lhMisaligned  0 1 00000105 00000000 0 00000000 1 0 0
lwAfterFault  0 2 00000100 00000000 0 beefaa44 0 0 0
lrWord        2 2 00000108 00000000 0 00000000 0 0 0
scOk          3 2 00000108 cafef00d 0 00000000 0 0 0
lwAfterSc     0 2 00000108 00000000 0 cafef00d 0 0 0
scNoRes       3 2 00000108 12345678 0 00000001 0 0 1
lwAfterNoRes  0 2 00000108 00000000 0 cafef00d 0 0 0
lrAgain       2 2 00000108 00000000 0 cafef00d 0 0 0
swIntervene   1 2 00000108 0badbeef 0 00000000 0 0 0
scAfterStore  3 2 00000108 77777777 0 00000001 0 0 1
lrOther       2 2 0000010c 00000000 0 00000000 0 0 0
scWrongWord   3 2 00000108 99999999 0 00000001 0 0 1
lwFinal       0 2 00000108 00000000 0 0badbeef 0 0 0
